//--- rtl/rv_core_defs.svh
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// Data and address width of the core
`define RV_XLEN 32

// Number of architectural integer registers
`define RV_NREGS 32

// First fetch address once reset is released
`define RV_RESET_PC 32'h0000_0000

`endif

//--- rtl/rv_core_pkg.sv
package rv_core_pkg;

    // Supported major opcodes
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } rv_opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_src_e;

    // Register write-back source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_PC4,
        WB_UIMM
    } wb_src_e;

    typedef enum logic [1:0] {
        PC_SEQ,
        PC_PC_IMM,
        PC_REG_IMM
    } pc_src_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        rv_opcode_e opcode;
    } rv_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        rv_opcode_e  opcode;
    } rv_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        rv_opcode_e opcode;
    } rv_s_t;

    // Branch offset bits are scattered over the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        rv_opcode_e opcode;
    } rv_b_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        rv_opcode_e  opcode;
    } rv_u_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        rv_opcode_e opcode;
    } rv_j_t;

    // One instruction word, viewed per encoding format
    typedef union packed {
        rv_r_t r;
        rv_i_t i;
        rv_s_t s;
        rv_b_t b;
        rv_u_t u;
        rv_j_t j;
    } rv_instr_u;

endpackage

//--- rtl/ctrl_if.sv
`timescale 1ns/100ps

interface ctrl_if;
    import rv_core_pkg::*;

    alu_op_e    alu_op;
    logic       alu_src_imm;
    imm_src_e   imm_src;
    wb_src_e    wb_src;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic [2:0] mem_funct3;
    logic       is_branch;
    logic       branch_ne;
    pc_src_e    jump_src;

    modport decoder (
        output alu_op, alu_src_imm, imm_src, wb_src, reg_write,
        output mem_read, mem_write, mem_funct3,
        output is_branch, branch_ne, jump_src
    );

    // Operand select, immediate format and next-PC control
    modport exec (
        input alu_op, alu_src_imm, imm_src, is_branch, branch_ne, jump_src
    );

    modport lsu (
        input mem_read, mem_write, mem_funct3
    );

endinterface

//--- rtl/fetch_unit.sv
`timescale 1ns/100ps

`include "rv_core_defs.svh"

module fetch_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               i_stall,
    input  logic               i_redirect,
    input  logic [`RV_XLEN-1:0] i_target,
    output logic [`RV_XLEN-1:0] o_pc,
    output logic [`RV_XLEN-1:0] o_pc_plus4
);

    logic [`RV_XLEN-1:0] pc_q;
    logic [`RV_XLEN-1:0] pc_d;

    assign o_pc       = pc_q;
    assign o_pc_plus4 = pc_q + `RV_XLEN'(4);

    // Taken branch or jump overrides the sequential path
    always_comb begin
        if (i_redirect) begin
            pc_d = i_target;
        end else begin
            pc_d = o_pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= `RV_RESET_PC;
        end else if (!i_stall) begin
            pc_q <= pc_d;
        end
    end

    // Targets from the execute unit must keep fetch on word boundaries
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) pc_q[1:0] == 2'b00
    ) else $error("PC not word aligned: %h", pc_q);

endmodule

//--- rtl/control.sv
`timescale 1ns/100ps

`include "rv_core_defs.svh"

module control (
    input  rv_core_pkg::rv_instr_u i_instr,
    input  logic                   i_instr_valid,
    ctrl_if.decoder                o_ctrl
);
    import rv_core_pkg::*;

    localparam int REG_AW = $clog2(`RV_NREGS);

    logic [REG_AW-1:0] rd_idx;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    alu_op_e           alu_fn;
    logic              alu_f3_ok;
    logic              reg_f7_ok;

    assign rd_idx = i_instr.r.rd;
    assign funct3 = i_instr.r.funct3;
    assign funct7 = i_instr.r.funct7;

    // Shared ALU decode of funct3 for OP and OP-IMM
    always_comb begin
        case (funct3)
            3'b010:  alu_fn = ALU_SLT;
            3'b100:  alu_fn = ALU_XOR;
            3'b110:  alu_fn = ALU_OR;
            3'b111:  alu_fn = ALU_AND;
            default: alu_fn = ALU_ADD;
        endcase
    end

    // Shift encodings are not implemented
    assign alu_f3_ok = funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
    assign reg_f7_ok = (funct7 == 7'h00) || (funct7 == 7'h20 && funct3 == 3'b000);

    always_comb begin
        o_ctrl.alu_op      = ALU_ADD;
        o_ctrl.alu_src_imm = 1'b0;
        o_ctrl.imm_src     = IMM_I;
        o_ctrl.wb_src      = WB_ALU;
        o_ctrl.reg_write   = 1'b0;
        o_ctrl.mem_read    = 1'b0;
        o_ctrl.mem_write   = 1'b0;
        o_ctrl.mem_funct3  = funct3;
        o_ctrl.is_branch   = 1'b0;
        o_ctrl.branch_ne   = 1'b0;
        o_ctrl.jump_src    = PC_SEQ;
        if (i_instr_valid) begin
            case (i_instr.r.opcode)
                OP_LUI: begin
                    o_ctrl.imm_src   = IMM_U;
                    o_ctrl.wb_src    = WB_UIMM;
                    o_ctrl.reg_write = 1'b1;
                end
                OP_JAL: begin
                    o_ctrl.imm_src   = IMM_J;
                    o_ctrl.wb_src    = WB_PC4;
                    o_ctrl.reg_write = 1'b1;
                    o_ctrl.jump_src  = PC_PC_IMM;
                end
                OP_JALR: begin
                    if (funct3 == 3'b000) begin
                        o_ctrl.wb_src    = WB_PC4;
                        o_ctrl.reg_write = 1'b1;
                        o_ctrl.jump_src  = PC_REG_IMM;
                    end
                end
                OP_BRANCH: begin
                    // Only beq and bne
                    if (funct3[2:1] == 2'b00) begin
                        o_ctrl.imm_src   = IMM_B;
                        o_ctrl.is_branch = 1'b1;
                        o_ctrl.branch_ne = funct3[0];
                    end
                end
                OP_LOAD: begin
                    if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
                        o_ctrl.alu_src_imm = 1'b1;
                        o_ctrl.mem_read    = 1'b1;
                        o_ctrl.wb_src      = WB_LOAD;
                        o_ctrl.reg_write   = 1'b1;
                    end
                end
                OP_STORE: begin
                    if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
                        o_ctrl.imm_src     = IMM_S;
                        o_ctrl.alu_src_imm = 1'b1;
                        o_ctrl.mem_write   = 1'b1;
                    end
                end
                OP_IMM: begin
                    if (alu_f3_ok) begin
                        o_ctrl.alu_op      = alu_fn;
                        o_ctrl.alu_src_imm = 1'b1;
                        o_ctrl.reg_write   = 1'b1;
                    end
                end
                OP_REG: begin
                    if (alu_f3_ok && reg_f7_ok) begin
                        o_ctrl.alu_op    = funct7[5] ? ALU_SUB : alu_fn;
                        o_ctrl.reg_write = 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
        // x0 is never written
        if (rd_idx == '0) begin
            o_ctrl.reg_write = 1'b0;
        end
    end

    // A single data port cannot read and write in the same access
    always_comb begin
        assert (!(o_ctrl.mem_read && o_ctrl.mem_write))
            else $error("mem_read and mem_write both high");
    end

endmodule

//--- rtl/regfile.sv
`timescale 1ns/100ps

`include "rv_core_defs.svh"

module regfile (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [$clog2(`RV_NREGS)-1:0] i_rs1,
    input  logic [$clog2(`RV_NREGS)-1:0] i_rs2,
    input  logic [$clog2(`RV_NREGS)-1:0] i_rd,
    input  logic                        i_we,
    input  logic [`RV_XLEN-1:0]          i_wdata,
    output logic [`RV_XLEN-1:0]          o_rdata1,
    output logic [`RV_XLEN-1:0]          o_rdata2
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < `RV_NREGS; k++) begin
                regs[k] <= '0;
            end
        end else if (i_we && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // Asynchronous reads, x0 hardwired to zero
    assign o_rdata1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

//--- rtl/execute_unit.sv
`timescale 1ns/100ps

`include "rv_core_defs.svh"

module execute_unit (
    input  rv_core_pkg::rv_instr_u i_instr,
    input  logic [`RV_XLEN-1:0]    i_pc,
    input  logic [`RV_XLEN-1:0]    i_rs1_data,
    input  logic [`RV_XLEN-1:0]    i_rs2_data,
    ctrl_if.exec                   i_ctrl,
    output logic [`RV_XLEN-1:0]    o_alu_result,
    output logic [`RV_XLEN-1:0]    o_imm,
    output logic                   o_redirect,
    output logic [`RV_XLEN-1:0]    o_target
);
    import rv_core_pkg::*;

    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] pc_imm;
    logic [`RV_XLEN-1:0] reg_imm;
    logic                rs_equal;
    logic                take_branch;

    // Immediate assembly per format
    always_comb begin
        case (i_ctrl.imm_src)
            IMM_I: o_imm = {{20{i_instr.i.imm[11]}}, i_instr.i.imm};
            IMM_S: o_imm = {{20{i_instr.s.imm_hi[6]}}, i_instr.s.imm_hi, i_instr.s.imm_lo};
            IMM_B: o_imm = {{19{i_instr.b.imm12}}, i_instr.b.imm12, i_instr.b.imm11,
                            i_instr.b.imm10_5, i_instr.b.imm4_1, 1'b0};
            IMM_U: o_imm = {i_instr.u.imm31_12, 12'b0};
            IMM_J: o_imm = {{11{i_instr.j.imm20}}, i_instr.j.imm20, i_instr.j.imm19_12,
                            i_instr.j.imm11, i_instr.j.imm10_1, 1'b0};
            default: o_imm = '0;
        endcase
    end

    assign op_b = i_ctrl.alu_src_imm ? o_imm : i_rs2_data;

    always_comb begin
        case (i_ctrl.alu_op)
            ALU_SUB: o_alu_result = i_rs1_data - op_b;
            ALU_AND: o_alu_result = i_rs1_data & op_b;
            ALU_OR:  o_alu_result = i_rs1_data | op_b;
            ALU_XOR: o_alu_result = i_rs1_data ^ op_b;
            ALU_SLT: begin
                o_alu_result = {{(`RV_XLEN-1){1'b0}},
                                $signed(i_rs1_data) < $signed(op_b)};
            end
            default: o_alu_result = i_rs1_data + op_b;
        endcase
    end

    // beq takes on equal, bne on not equal
    assign rs_equal    = (i_rs1_data == i_rs2_data);
    assign take_branch = i_ctrl.is_branch && (rs_equal ^ i_ctrl.branch_ne);

    assign pc_imm  = i_pc + o_imm;
    assign reg_imm = i_rs1_data + o_imm;

    assign o_redirect = take_branch || (i_ctrl.jump_src != PC_SEQ);

    // jalr drops bit 0 of the sum
    always_comb begin
        if (i_ctrl.jump_src == PC_REG_IMM) begin
            o_target = {reg_imm[`RV_XLEN-1:1], 1'b0};
        end else begin
            o_target = pc_imm;
        end
    end

endmodule

//--- rtl/load_store_unit.sv
`timescale 1ns/100ps

`include "rv_core_defs.svh"

module load_store_unit (
    input  logic [`RV_XLEN-1:0]   i_addr,
    input  logic [`RV_XLEN-1:0]   i_rs2_data,
    ctrl_if.lsu                   i_ctrl,
    input  logic                  i_dmem_valid,
    input  logic [`RV_XLEN-1:0]   i_dmem_rdata,
    output logic [`RV_XLEN-1:0]   o_dmem_addr,
    output logic [`RV_XLEN-1:0]   o_dmem_wdata,
    output logic [`RV_XLEN/8-1:0] o_dmem_be,
    output logic                  o_dmem_we,
    output logic                  o_dmem_re,
    output logic [`RV_XLEN-1:0]   o_load_data,
    output logic                  o_mem_stall
);

    logic [`RV_XLEN/8-1:0] lanes;
    logic [`RV_XLEN-1:0]   shifted;

    assign o_dmem_addr = {i_addr[`RV_XLEN-1:2], 2'b00};
    assign o_dmem_we   = i_ctrl.mem_write;
    assign o_dmem_re   = i_ctrl.mem_read;

    // Held until the memory accepts the access
    assign o_mem_stall = (o_dmem_we || o_dmem_re) && !i_dmem_valid;

    // Size from funct3[1:0], lane from the low address bits
    always_comb begin
        case (i_ctrl.mem_funct3[1:0])
            2'b00: begin
                o_dmem_wdata = {4{i_rs2_data[7:0]}};
                lanes        = 4'b0001 << i_addr[1:0];
            end
            2'b01: begin
                o_dmem_wdata = {2{i_rs2_data[15:0]}};
                lanes        = i_addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                o_dmem_wdata = i_rs2_data;
                lanes        = 4'b1111;
            end
        endcase
    end

    // Strobes only qualify writes
    assign o_dmem_be = o_dmem_we ? lanes : '0;

    assign shifted = i_dmem_rdata >> {i_addr[1:0], 3'b000};

    always_comb begin
        case (i_ctrl.mem_funct3)
            3'b000:  o_load_data = {{24{shifted[7]}}, shifted[7:0]};
            3'b001:  o_load_data = {{16{shifted[15]}}, shifted[15:0]};
            3'b100:  o_load_data = {24'b0, shifted[7:0]};
            3'b101:  o_load_data = {16'b0, shifted[15:0]};
            default: o_load_data = i_dmem_rdata;
        endcase
    end

    // Program and ALU must never produce an odd halfword address
    always_comb begin
        if ((o_dmem_we || o_dmem_re) && i_ctrl.mem_funct3[1:0] == 2'b01) begin
            assert (i_addr[0] == 1'b0)
                else $error("odd halfword access at %h", i_addr);
        end
    end

endmodule

//--- rtl/rv_core.sv
`timescale 1ns/100ps

`include "rv_core_defs.svh"

module rv_core (
    input  logic                  clk,
    input  logic                  rst_n,
    output logic [`RV_XLEN-1:0]   o_imem_addr,
    input  logic [`RV_XLEN-1:0]   i_imem_data,
    input  logic                  i_imem_valid,
    output logic [`RV_XLEN-1:0]   o_dmem_addr,
    output logic [`RV_XLEN-1:0]   o_dmem_wdata,
    output logic [`RV_XLEN/8-1:0] o_dmem_be,
    output logic                  o_dmem_we,
    output logic                  o_dmem_re,
    input  logic [`RV_XLEN-1:0]   i_dmem_rdata,
    input  logic                  i_dmem_valid
);
    import rv_core_pkg::*;

    rv_instr_u           instr;
    logic                instr_valid;
    logic                mem_stall;
    logic                stall;
    logic                redirect;
    logic [`RV_XLEN-1:0] target;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] load_data;
    logic [`RV_XLEN-1:0] wb_data;
    logic                reg_we;

    assign instr = i_imem_data;

    // Nothing counts as fetched while in reset
    assign instr_valid = i_imem_valid && rst_n;
    assign stall       = !instr_valid || mem_stall;
    assign reg_we      = u_ctrl.reg_write && !stall;

    ctrl_if u_ctrl ();

    fetch_unit u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_stall    (stall),
        .i_redirect (redirect),
        .i_target   (target),
        .o_pc       (o_imem_addr),
        .o_pc_plus4 (pc_plus4)
    );

    control u_control (
        .i_instr       (instr),
        .i_instr_valid (instr_valid),
        .o_ctrl        (u_ctrl)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_rs1    (instr.r.rs1),
        .i_rs2    (instr.r.rs2),
        .i_rd     (instr.r.rd),
        .i_we     (reg_we),
        .i_wdata  (wb_data),
        .o_rdata1 (rs1_data),
        .o_rdata2 (rs2_data)
    );

    execute_unit u_execute (
        .i_instr      (instr),
        .i_pc         (o_imem_addr),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .i_ctrl       (u_ctrl),
        .o_alu_result (alu_result),
        .o_imm        (imm),
        .o_redirect   (redirect),
        .o_target     (target)
    );

    load_store_unit u_lsu (
        .i_addr       (alu_result),
        .i_rs2_data   (rs2_data),
        .i_ctrl       (u_ctrl),
        .i_dmem_valid (i_dmem_valid),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_be    (o_dmem_be),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_re    (o_dmem_re),
        .o_load_data  (load_data),
        .o_mem_stall  (mem_stall)
    );

    // Write-back select
    always_comb begin
        case (u_ctrl.wb_src)
            WB_LOAD: wb_data = load_data;
            WB_PC4:  wb_data = pc_plus4;
            WB_UIMM: wb_data = imm;
            default: wb_data = alu_result;
        endcase
    end

endmodule

//--- dv/tb_memory.sv
`timescale 1ns/100ps

`include "rv_core_defs.svh"

module tb_memory (
    input  logic                  clk,
    input  logic [`RV_XLEN-1:0]   i_imem_addr,
    output logic [`RV_XLEN-1:0]   o_imem_data,
    output logic                  o_imem_valid,
    input  logic [`RV_XLEN-1:0]   i_dmem_addr,
    input  logic [`RV_XLEN-1:0]   i_dmem_wdata,
    input  logic [`RV_XLEN/8-1:0] i_dmem_be,
    input  logic                  i_dmem_we,
    input  logic                  i_dmem_re,
    output logic [`RV_XLEN-1:0]   o_dmem_rdata,
    output logic                  o_dmem_valid
);

    logic [31:0] rom [64];
    logic [31:0] ram [64];
    integer      seed;

    function automatic logic [31:0] r_type(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
                                           int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(int imm, int rs1, logic [2:0] f3, int rd,
                                           logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] s_type(int imm, int rs2, int rs1, logic [2:0] f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(int imm, int rs2, int rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(int imm20, int rd);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] j_type(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    initial begin
        seed         = 16108;
        o_imem_valid = 1'b0;
        o_dmem_valid = 1'b0;
        for (int k = 0; k < 64; k++) begin
            // Opcode 0 is unsupported, so a stray fetch retires as a no-op
            rom[k] = {25'(k), 7'b0000000};
            ram[k] = 32'hC0DE_0000 | 32'(k << 2);
        end
        // ALU and immediates, results at 0x80 upwards
        rom[0]  = i_type(-5, 0, 3'b000, 1, 7'b0010011);
        rom[1]  = i_type(7, 0, 3'b000, 2, 7'b0010011);
        rom[2]  = u_type(32'h80001, 3);
        rom[3]  = s_type(32'h80, 3, 0, 3'b010);
        rom[4]  = r_type(7'h00, 2, 1, 3'b000, 4);
        rom[5]  = s_type(32'h84, 4, 0, 3'b010);
        rom[6]  = r_type(7'h20, 2, 1, 3'b000, 4);
        rom[7]  = s_type(32'h88, 4, 0, 3'b010);
        rom[8]  = r_type(7'h00, 3, 1, 3'b111, 4);
        rom[9]  = s_type(32'h8C, 4, 0, 3'b010);
        rom[10] = r_type(7'h00, 2, 1, 3'b110, 4);
        rom[11] = s_type(32'h90, 4, 0, 3'b010);
        rom[12] = r_type(7'h00, 2, 1, 3'b100, 4);
        rom[13] = s_type(32'h94, 4, 0, 3'b010);
        rom[14] = r_type(7'h00, 2, 1, 3'b010, 4);
        rom[15] = s_type(32'h98, 4, 0, 3'b010);
        rom[16] = i_type(-1, 2, 3'b010, 4, 7'b0010011);
        rom[17] = s_type(32'h9C, 4, 0, 3'b010);
        rom[18] = i_type(32'h0F0, 1, 3'b111, 4, 7'b0010011);
        rom[19] = s_type(32'hA0, 4, 0, 3'b010);
        rom[20] = i_type(-256, 2, 3'b110, 4, 7'b0010011);
        rom[21] = s_type(32'hA4, 4, 0, 3'b010);
        rom[22] = i_type(32'h555, 1, 3'b100, 4, 7'b0010011);
        rom[23] = s_type(32'hA8, 4, 0, 3'b010);
        // Sub-word stores at every legal offset
        rom[24] = u_type(32'h08765, 5);
        rom[25] = i_type(32'h4A5, 5, 3'b000, 5, 7'b0010011);
        rom[26] = s_type(32'h40, 5, 0, 3'b000);
        rom[27] = s_type(32'h41, 5, 0, 3'b000);
        rom[28] = s_type(32'h42, 5, 0, 3'b000);
        rom[29] = s_type(32'h43, 5, 0, 3'b000);
        rom[30] = s_type(32'h44, 5, 0, 3'b001);
        rom[31] = s_type(32'h46, 5, 0, 3'b001);
        rom[32] = s_type(32'h48, 1, 0, 3'b010);
        // Loads stored back
        rom[33] = i_type(32'h44, 0, 3'b000, 6, 7'b0000011);
        rom[34] = s_type(32'hAC, 6, 0, 3'b010);
        rom[35] = i_type(32'h45, 0, 3'b100, 6, 7'b0000011);
        rom[36] = s_type(32'hB0, 6, 0, 3'b010);
        rom[37] = i_type(32'h48, 0, 3'b001, 6, 7'b0000011);
        rom[38] = s_type(32'hB4, 6, 0, 3'b010);
        rom[39] = i_type(32'h4A, 0, 3'b101, 6, 7'b0000011);
        rom[40] = s_type(32'hB8, 6, 0, 3'b010);
        rom[41] = i_type(32'h44, 0, 3'b010, 6, 7'b0000011);
        rom[42] = s_type(32'hBC, 6, 0, 3'b010);
        // Branches; each store to 0xFC must be skipped
        rom[43] = b_type(8, 1, 1, 3'b000);
        rom[44] = s_type(32'hFC, 0, 0, 3'b010);
        rom[45] = b_type(8, 2, 1, 3'b001);
        rom[46] = s_type(32'hFC, 0, 0, 3'b010);
        rom[47] = b_type(8, 1, 1, 3'b001);
        rom[48] = s_type(32'hC0, 2, 0, 3'b010);
        rom[49] = b_type(8, 2, 1, 3'b000);
        rom[50] = s_type(32'hC4, 1, 0, 3'b010);
        rom[51] = j_type(8, 7);
        rom[52] = s_type(32'hFC, 0, 0, 3'b010);
        rom[53] = s_type(32'hC8, 7, 0, 3'b010);
        rom[54] = i_type(32'hE0, 0, 3'b000, 8, 7'b0010011);
        rom[55] = i_type(4, 8, 3'b000, 9, 7'b1100111);
        rom[56] = s_type(32'hFC, 0, 0, 3'b010);
        rom[57] = s_type(32'hCC, 9, 0, 3'b010);
        // Done marker, then spin
        rom[58] = u_type(6, 11);
        rom[59] = i_type(13, 11, 3'b000, 11, 7'b0010011);
        rom[60] = s_type(32'h1FC, 11, 0, 3'b010);
        rom[61] = j_type(0, 0);
    end

    assign o_imem_data  = rom[i_imem_addr[7:2]];

    // Read data only while a load is issued
    assign o_dmem_rdata = i_dmem_re ? ram[i_dmem_addr[7:2]] : '0;

    // Each valid drops on roughly one cycle in three
    always @(negedge clk) begin
        o_imem_valid <= ($random(seed) % 3) != 0;
        o_dmem_valid <= ($random(seed) % 3) != 0;
    end

    always @(posedge clk) begin
        if (i_dmem_we && o_dmem_valid) begin
            for (int b = 0; b < 4; b++) begin
                if (i_dmem_be[b]) begin
                    ram[i_dmem_addr[7:2]][b*8 +: 8] <= i_dmem_wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

//--- dv/tb_rv_core.sv
`timescale 1ns/100ps

`include "rv_core_defs.svh"

module tb_rv_core;

    localparam int          PROG_LEN   = 62;
    // Every instruction may be stalled for several cycles
    localparam int          MAX_CYCLES = PROG_LEN * 8 + 4;
    localparam logic [31:0] DONE_ADDR  = 32'h0000_01FC;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        imem_valid;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [3:0]  dmem_be;
    logic        dmem_we;
    logic        dmem_re;
    logic [31:0] dmem_rdata;
    logic        dmem_valid;
    logic        store_fire;

    logic [31:0] exp_addr [32];
    logic [3:0]  exp_be [32];
    logic [31:0] exp_data [32];
    int          n_exp;
    int          store_cnt;
    int          cycles;

    rv_core i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .o_imem_addr  (imem_addr),
        .i_imem_data  (imem_data),
        .i_imem_valid (imem_valid),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_wdata (dmem_wdata),
        .o_dmem_be    (dmem_be),
        .o_dmem_we    (dmem_we),
        .o_dmem_re    (dmem_re),
        .i_dmem_rdata (dmem_rdata),
        .i_dmem_valid (dmem_valid)
    );

    tb_memory u_mem (
        .clk          (clk),
        .i_imem_addr  (imem_addr),
        .o_imem_data  (imem_data),
        .o_imem_valid (imem_valid),
        .i_dmem_addr  (dmem_addr),
        .i_dmem_wdata (dmem_wdata),
        .i_dmem_be    (dmem_be),
        .i_dmem_we    (dmem_we),
        .i_dmem_re    (dmem_re),
        .o_dmem_rdata (dmem_rdata),
        .o_dmem_valid (dmem_valid)
    );

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic value_fail(string name, logic [31:0] exp, logic [31:0] act);
        $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
        stop_run();
    endtask

    task automatic text_fail(string msg);
        $display("Error at t=%0t: %s", $time, msg);
        stop_run();
    endtask

    function automatic logic [31:0] sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic void add_store(logic [31:0] addr, logic [3:0] be, logic [31:0] data);
        exp_addr[n_exp] = addr;
        exp_be[n_exp]   = be;
        exp_data[n_exp] = data;
        n_exp++;
    endfunction

    // Expected stores of the program, from the RV32I semantics
    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] u;
        logic [31:0] w;
        logic [31:0] m44;
        logic [31:0] m48;
        n_exp = 0;
        a     = -5;
        b     = 7;
        u     = {20'h80001, 12'h000};
        w     = {20'h08765, 12'h000} + sext12(12'h4A5);
        add_store(32'h80, 4'hF, u);
        add_store(32'h84, 4'hF, a + b);
        add_store(32'h88, 4'hF, a - b);
        add_store(32'h8C, 4'hF, a & u);
        add_store(32'h90, 4'hF, a | b);
        add_store(32'h94, 4'hF, a ^ b);
        add_store(32'h98, 4'hF, {31'b0, $signed(a) < $signed(b)});
        add_store(32'h9C, 4'hF, {31'b0, $signed(b) < $signed(sext12(12'hFFF))});
        add_store(32'hA0, 4'hF, a & sext12(12'h0F0));
        add_store(32'hA4, 4'hF, b | sext12(12'hF00));
        add_store(32'hA8, 4'hF, a ^ sext12(12'h555));
        for (int k = 0; k < 4; k++) begin
            add_store(32'h40, 4'b0001 << k, {4{w[7:0]}});
        end
        add_store(32'h44, 4'b0011, {2{w[15:0]}});
        add_store(32'h44, 4'b1100, {2{w[15:0]}});
        add_store(32'h48, 4'hF, a);
        m44 = {w[15:0], w[15:0]};
        m48 = a;
        add_store(32'hAC, 4'hF, {{24{m44[7]}}, m44[7:0]});
        add_store(32'hB0, 4'hF, {24'b0, m44[15:8]});
        add_store(32'hB4, 4'hF, {{16{m48[15]}}, m48[15:0]});
        add_store(32'hB8, 4'hF, {16'b0, m48[31:16]});
        add_store(32'hBC, 4'hF, m44);
        add_store(32'hC0, 4'hF, b);
        add_store(32'hC4, 4'hF, a);
        // Links of jal at 0xCC and jalr at 0xDC
        add_store(32'hC8, 4'hF, 32'hCC + 32'd4);
        add_store(32'hCC, 4'hF, 32'hDC + 32'd4);
    end

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
    end

    always #20 clk = ~clk;

    assign store_fire = dmem_we && dmem_valid && dmem_addr != DONE_ADDR;

    always @(posedge clk) begin
        if (!rst_n) begin
            store_cnt <= 0;
        end else if (store_fire) begin
            store_cnt <= store_cnt + 1;
        end
    end

    a_reset_idle: assert property (@(posedge clk) !rst_n |-> !dmem_we && !dmem_re)
        else text_fail("data access issued during reset");
    a_reset_pc: assert property (@(posedge clk) !rst_n |=> imem_addr == `RV_RESET_PC)
        else value_fail("o_imem_addr", `RV_RESET_PC, $sampled(imem_addr));
    a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !imem_valid |=> $stable(imem_addr))
        else text_fail("PC advanced without a valid instruction");
    a_store_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (dmem_we && !dmem_valid) |=>
        (!dmem_we || ($stable(dmem_addr) && $stable(dmem_wdata) && $stable(dmem_be))))
        else text_fail("waiting store changed address, data or strobes");
    a_store_count: assert property (@(posedge clk) disable iff (!rst_n)
        store_fire |-> store_cnt < n_exp)
        else text_fail("more stores completed than expected");
    a_store_addr: assert property (@(posedge clk) disable iff (!rst_n)
        store_fire |-> dmem_addr == exp_addr[store_cnt])
        else value_fail("o_dmem_addr", $sampled(exp_addr[store_cnt]), $sampled(dmem_addr));
    a_store_be: assert property (@(posedge clk) disable iff (!rst_n)
        store_fire |-> dmem_be == exp_be[store_cnt])
        else value_fail("o_dmem_be", 32'($sampled(exp_be[store_cnt])), 32'($sampled(dmem_be)));
    a_store_data: assert property (@(posedge clk) disable iff (!rst_n)
        store_fire |-> dmem_wdata == exp_data[store_cnt])
        else value_fail("o_dmem_wdata", $sampled(exp_data[store_cnt]), $sampled(dmem_wdata));

    // Final marker store ends the run
    always @(posedge clk) begin
        if (rst_n && dmem_we && dmem_valid && dmem_addr == DONE_ADDR) begin
            if (dmem_wdata != 32'h600D) begin
                value_fail("o_dmem_wdata", 32'h600D, dmem_wdata);
            end else if (store_cnt != n_exp) begin
                text_fail("final store reached before all expected stores completed");
            end else begin
                $display("Test OK");
                $finish;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            cycles <= 0;
        end else if (cycles >= MAX_CYCLES) begin
            text_fail("program did not reach its final store before the cycle limit");
        end else begin
            cycles <= cycles + 1;
        end
    end

endmodule

//--- project.f
+incdir+rtl
rtl/rv_core_pkg.sv
rtl/ctrl_if.sv
rtl/fetch_unit.sv
rtl/control.sv
rtl/regfile.sv
rtl/execute_unit.sv
rtl/load_store_unit.sv
rtl/rv_core.sv
dv/tb_memory.sv
dv/tb_rv_core.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator.
# The exit status is nonzero when the build fails or the testbench stops on $fatal.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f project.f \
    --top-module tb_rv_core \
    -o sim_rv_core \
    && ./obj_dir/sim_rv_core \
    || exit 1
